// File: Bender.yml
package:
  name: pet_bus

sources:
  # packages first, the RTL depends on them
  - src/pet_bus_pkg.sv
  - src/pet_timing_pkg.sv
  - src/pet_slot_timer.sv
  - src/bus_client_port.sv
  - src/bus_arbiter.sv
  - src/pet_shared_ram.sv
  - src/pet_bus_top.sv
  - target: test
    files:
      - test/pet_bus_tb.sv

// File: compile.f
src/pet_bus_pkg.sv
src/pet_timing_pkg.sv
src/pet_slot_timer.sv
src/bus_client_port.sv
src/bus_arbiter.sv
src/pet_shared_ram.sv
src/pet_bus_top.sv
test/pet_bus_tb.sv

// File: src/bus_arbiter.sv
/*
 * Slot arbiter for the shared RAM.
 * In phase 0 of a slot the owning client is granted if its port holds a
 * request, and that request drives the RAM. The served client is
 * remembered so that the strobe cycle returns the read data to it alone.
 */
`timescale 1ns/1ps

module bus_arbiter
    import pet_bus_pkg::*;
    import pet_timing_pkg::*;
(
    input  logic                              clk_16_i,
    input  logic                              rst_i,
    // frame schedule
    input  slot_vec_t                         slot_i,
    input  logic                              bus_strobe_i,
    // client ports
    input  client_vec_t                       pend_valid_i,
    input  bus_req_t    [NUM_CLIENTS-1:0]     pend_req_i,
    output client_vec_t                       grant_o,
    // shared ram
    output logic                              ram_en_o,
    output logic                              ram_we_o,
    output bus_addr_t                         ram_addr_o,
    output bus_data_t                         ram_wdata_o,
    input  bus_data_t                         ram_rdata_i,
    // responses
    output client_vec_t                       rsp_valid_o,
    output bus_rsp_t    [NUM_CLIENTS-1:0]     rsp_o
);

    // client whose access is in flight in the ram
    client_vec_t served_q;

    // slot owner with a pending request, phase 0 only
    // at most one bit is set since slots are distinct
    always_comb begin
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            grant_o[c] = !bus_strobe_i && slot_i[CLIENT_SLOT[c]] && pend_valid_i[c];
        end
    end

    // ram mux, one-hot grant selects the request
    always_comb begin
        ram_we_o    = 1'b0;
        ram_addr_o  = '0;
        ram_wdata_o = '0;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (grant_o[c]) begin
                ram_we_o    = pend_req_i[c].we;
                ram_addr_o  = pend_req_i[c].addr;
                ram_wdata_o = pend_req_i[c].wdata;
            end
        end
    end

    assign ram_en_o = |grant_o;

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            served_q <= '0;
        end else begin
            served_q <= grant_o;
        end
    end

    // read data lands in the strobe cycle
    always_comb begin
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            rsp_valid_o[c]    = served_q[c] && bus_strobe_i;
            rsp_o[c].rdata    = served_q[c] ? ram_rdata_i : '0;
        end
    end

endmodule

// File: src/bus_client_port.sv
/*
 * Request queue in front of one bus client.
 * Accepts requests on a valid/ready handshake into a circular FIFO of
 * PORT_DEPTH entries and presents the oldest one to the arbiter.
 * The head entry is popped in any cycle where grant_i is high.
 * Slot ownership lives in the arbiter, not here.
 */
`timescale 1ns/1ps

module bus_client_port
    import pet_bus_pkg::*;
#(
    parameter int unsigned PORT_DEPTH = 2
) (
    input  logic     clk_16_i,
    input  logic     rst_i,
    // client side
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,
    // arbiter side
    output logic     pend_valid_o,
    output bus_req_t pend_req_o,
    input  logic     grant_i
);

    localparam int unsigned PTR_W = (PORT_DEPTH > 1) ? $clog2(PORT_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(PORT_DEPTH + 1);

    bus_req_t             queue_q [PORT_DEPTH];
    logic     [PTR_W-1:0] wr_ptr_q;
    logic     [PTR_W-1:0] rd_ptr_q;
    logic     [CNT_W-1:0] count_q;
    logic     [CNT_W-1:0] count_next;
    logic                 ready_q;
    logic                 push;
    logic                 pop;

    // ready is registered so that it is low through reset
    // and does not look at valid
    assign push = req_valid_i & ready_q;
    assign pop  = grant_i & pend_valid_o;

    always_comb begin
        count_next = count_q;
        if (push && !pop) begin
            count_next = count_q + CNT_W'(1);
        end else if (pop && !push) begin
            count_next = count_q - CNT_W'(1);
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ready_q  <= 1'b0;
        end else begin
            count_q <= count_next;
            // full queue holds ready low until the next grant
            ready_q <= (count_next != CNT_W'(PORT_DEPTH));
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(PORT_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(PORT_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
        end
    end

    // payload storage
    always_ff @(posedge clk_16_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= req_i;
        end
    end

    assign req_ready_o  = ready_q;
    assign pend_valid_o = (count_q != '0);
    assign pend_req_o   = queue_q[rd_ptr_q];

endmodule

// File: src/pet_bus_pkg.sv
/*
 * Bus payload types for the shared-memory bus.
 * Import wherever requests, responses or RAM addresses cross a port.
 * Sizes follow the 4 KB shared RAM and the 8-bit data bus of the PET.
 */
package pet_bus_pkg;

    // 12 address bits cover the 4 KB shared RAM
    parameter int unsigned ADDR_WIDTH = 12;
    parameter int unsigned DATA_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [DATA_WIDTH-1:0] bus_data_t;

    // one bus request, 21 bits
    typedef struct packed {
        bus_addr_t addr;
        // high for a write, low for a read
        logic      we;
        // ignored on reads
        bus_data_t wdata;
    } bus_req_t;

    // one response, always the old RAM contents
    // (a write also returns what it overwrote)
    typedef struct packed {
        bus_data_t rdata;
    } bus_rsp_t;

endpackage

// File: src/pet_bus_top.sv
/*
 * Top of the shared-memory bus timing core.
 * Slot timer, one request port per client, the arbiter and the RAM.
 * Each client talks valid/ready requests in and one-cycle responses out.
 */
`timescale 1ns/1ps

module pet_bus_top
    import pet_bus_pkg::*;
    import pet_timing_pkg::*;
#(
    parameter int unsigned PORT_DEPTH = 2
) (
    input  logic                          clk_16_i,
    input  logic                          rst_i,
    input  client_vec_t                   req_valid_i,
    input  bus_req_t    [NUM_CLIENTS-1:0] req_i,
    output client_vec_t                   req_ready_o,
    output client_vec_t                   rsp_valid_o,
    output bus_rsp_t    [NUM_CLIENTS-1:0] rsp_o,
    output logic                          clk_8_o,
    output logic                          clk_cpu_o
);

    slot_vec_t                    slot;
    logic                         bus_strobe;
    client_vec_t                  pend_valid;
    bus_req_t [NUM_CLIENTS-1:0]   pend_req;
    client_vec_t                  grant;
    logic                         ram_en;
    logic                         ram_we;
    bus_addr_t                    ram_addr;
    bus_data_t                    ram_wdata;
    bus_data_t                    ram_rdata;

    pet_slot_timer u_timer (
        .clk_16_i     (clk_16_i),
        .rst_i        (rst_i),
        .slot_o       (slot),
        .bus_strobe_o (bus_strobe),
        .clk_8_o      (clk_8_o),
        .clk_cpu_o    (clk_cpu_o)
    );

    // one queue per client, all alike
    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_port
        bus_client_port #(
            .PORT_DEPTH (PORT_DEPTH)
        ) u_port (
            .clk_16_i     (clk_16_i),
            .rst_i        (rst_i),
            .req_valid_i  (req_valid_i[i]),
            .req_i        (req_i[i]),
            .req_ready_o  (req_ready_o[i]),
            .pend_valid_o (pend_valid[i]),
            .pend_req_o   (pend_req[i]),
            .grant_i      (grant[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk_16_i     (clk_16_i),
        .rst_i        (rst_i),
        .slot_i       (slot),
        .bus_strobe_i (bus_strobe),
        .pend_valid_i (pend_valid),
        .pend_req_i   (pend_req),
        .grant_o      (grant),
        .ram_en_o     (ram_en),
        .ram_we_o     (ram_we),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_rdata_i  (ram_rdata),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

    pet_shared_ram u_ram (
        .clk_16_i (clk_16_i),
        .en_i     (ram_en),
        .we_i     (ram_we),
        .addr_i   (ram_addr),
        .wdata_i  (ram_wdata),
        .rdata_o  (ram_rdata)
    );

endmodule

// File: src/pet_shared_ram.sv
/*
 * Shared 4 KB RAM behind the bus arbiter.
 * Single port, synchronous, read-before-write: data appears one cycle
 * after an enabled access and is the contents before any write.
 * Starts out cleared to zero.
 */
`timescale 1ns/1ps

module pet_shared_ram
    import pet_bus_pkg::*;
(
    input  logic      clk_16_i,
    input  logic      en_i,
    input  logic      we_i,
    input  bus_addr_t addr_i,
    input  bus_data_t wdata_i,
    output bus_data_t rdata_o
);

    bus_data_t mem [2**ADDR_WIDTH];

    // power-up contents
    initial begin
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (en_i) begin
            // old contents out, even on a write
            rdata_o <= mem[addr_i];
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
        end
    end

endmodule

// File: src/pet_slot_timer.sv
/*
 * Frame schedule of the shared bus.
 * Counts clk_16 cycles into slots and rotates a one-hot slot register.
 * Derives the 8 MHz bus clock, the bus strobe and the gated CPU clock.
 * Everything runs on the rising clk_16 edge; the strobe in the last
 * phase of a slot marks where read data is valid.
 */
`timescale 1ns/1ps

module pet_slot_timer
    import pet_timing_pkg::*;
(
    input  logic      clk_16_i,
    input  logic      rst_i,
    output slot_vec_t slot_o,
    output logic      bus_strobe_o,
    output logic      clk_8_o,
    output logic      clk_cpu_o
);

    localparam int unsigned PHASE_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;

    // cycle within the current slot
    logic [PHASE_W-1:0] phase_q;
    logic               last_phase;
    slot_vec_t          slot_q;

    assign last_phase = (phase_q == PHASE_W'(SLOT_CYCLES - 1));

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            // frame restarts at slot 0, phase 0
            phase_q <= '0;
            slot_q  <= slot_vec_t'(1);
        end else begin
            if (last_phase) begin
                phase_q <= '0;
                // hand the bus to the next slot
                slot_q  <= {slot_q[NUM_SLOTS-2:0], slot_q[NUM_SLOTS-1]};
            end else begin
                phase_q <= phase_q + PHASE_W'(1);
            end
        end
    end

    assign slot_o = slot_q;

    // strobe in the second half of every slot
    // stands in for the offset clock of the original board
    assign bus_strobe_o = last_phase;

    // bus clock low in phase 0, high in phase 1
    assign clk_8_o = last_phase;

    // one cpu clock pulse per frame, inside the cpu's own slot
    assign clk_cpu_o = clk_8_o & slot_q[CLIENT_SLOT[CLIENT_CPU]];

endmodule

// File: src/pet_timing_pkg.sv
/*
 * Frame geometry of the bus timing core.
 * A frame is NUM_SLOTS slots of SLOT_CYCLES clk_16 cycles each.
 * CLIENT_SLOT fixes which slot each bus client owns.
 */
package pet_timing_pkg;

    parameter int unsigned NUM_SLOTS   = 8;
    parameter int unsigned SLOT_CYCLES = 2;
    parameter int unsigned NUM_CLIENTS = 3;

    // bits needed to name a slot
    parameter int unsigned SLOT_W = $clog2(NUM_SLOTS);

    // client indices
    parameter int unsigned CLIENT_CPU   = 0;
    parameter int unsigned CLIENT_VIDEO = 1;
    parameter int unsigned CLIENT_SPI   = 2;

    // client index -> owned slot
    // element 0 (lsb) is the cpu: cpu 7, video 1, spi 3
    parameter logic [NUM_CLIENTS-1:0][SLOT_W-1:0] CLIENT_SLOT = {
        SLOT_W'(3), SLOT_W'(1), SLOT_W'(7)
    };

    // one-hot, marks the current slot
    typedef logic [NUM_SLOTS-1:0] slot_vec_t;

    // one bit per client
    typedef logic [NUM_CLIENTS-1:0] client_vec_t;

endpackage

// File: test/pet_bus_tb.sv
/*
 * Self-checking testbench for the shared-memory bus timing core.
 * Drives request streams for the cpu, video and spi clients, models the
 * RAM in a reference function and checks data, ordering and latency of
 * every response. Run with compile.f and pet_bus_tb as the top.
 */
`timescale 1ns/1ps

module pet_bus_tb
    import pet_bus_pkg::*;
    import pet_timing_pkg::*;
();

    localparam int PORT_DEPTH = 2;
    localparam int N_RAND     = 20;
    localparam int N_FLOOD    = 4 * PORT_DEPTH + 2;
    localparam int NUM_REQ    = 3 + NUM_CLIENTS * N_RAND + N_FLOOD;
    // worst case per request plus room for reset, clock test and idle gaps
    localparam int LIMIT      = NUM_REQ * 16 * (PORT_DEPTH + 1) + 500;

    // one expected response
    typedef struct packed {
        logic [7:0] data;
        int         acc;
        int         limit;
    } exp_t;

    logic                         clk;
    logic                         rst;
    client_vec_t                  req_valid;
    bus_req_t [NUM_CLIENTS-1:0]   req;
    client_vec_t                  req_ready;
    client_vec_t                  rsp_valid;
    bus_rsp_t [NUM_CLIENTS-1:0]   rsp;
    logic                         clk_8;
    logic                         clk_cpu;

    bit [7:0] ref_mem [2**ADDR_WIDTH];
    exp_t     exp_q [NUM_CLIENTS][$];
    int       last_rsp [NUM_CLIENTS] = '{default: -100};
    bit       stall_seen [NUM_CLIENTS];
    int       cyc;
    int       err_cnt;
    int       tests_ok;
    int       tests_bad;

    pet_bus_top #(
        .PORT_DEPTH (PORT_DEPTH)
    ) DUT (
        .clk_16_i    (clk),
        .rst_i       (rst),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .clk_8_o     (clk_8),
        .clk_cpu_o   (clk_cpu)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // memory model: old contents out, then the write
    function automatic logic [7:0] ref_access(input bus_req_t r);
        logic [7:0] old;
        old = ref_mem[r.addr];
        if (r.we) begin
            ref_mem[r.addr] = r.wdata;
        end
        return old;
    endfunction

    // call right after a falling edge, returns after the next one
    task automatic send_req(input int c, input bus_req_t r);
        exp_t e;
        req_valid[c] = 1'b1;
        req[c]       = r;
        while (!req_ready[c]) begin
            stall_seen[c] = 1'b1;
            // ready low only with a full queue
            compare_values("requests outstanding while stalled",
                           exp_q[c].size() >= PORT_DEPTH, 1);
            @(negedge clk);
        end
        compare_values("requests outstanding at accept", exp_q[c].size() <= PORT_DEPTH, 1);
        // transfer on the coming rising edge
        e.data  = ref_access(r);
        e.acc   = cyc + 1;
        e.limit = 16 * (exp_q[c].size() + 1) + 2;
        exp_q[c].push_back(e);
        @(negedge clk);
        req_valid[c] = 1'b0;
    endtask

    task automatic drive_random(input int c);
        bus_req_t r;
        for (int i = 0; i < N_RAND; i++) begin
            // small window per client so addresses get reused
            r.addr  = bus_addr_t'(c * 'h400 + $urandom % 16);
            r.we    = $urandom % 2;
            r.wdata = $urandom;
            send_req(c, r);
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) != 0 &&
               waited < 16 * (PORT_DEPTH + 1) + 4) begin
            @(negedge clk);
            waited++;
        end
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (exp_q[c].size() != 0) begin
                $display("client %0d: %0d responses never arrived", c, exp_q[c].size());
                err_cnt++;
            end
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // checks every response against the head of that client's queue
    always @(posedge clk) begin : compare_rsp
        exp_t e;
        int   now;
        now = cyc + 1;
        for (int c = 0; c < NUM_CLIENTS; c++) begin
            if (!rst && rsp_valid[c]) begin
                if (exp_q[c].size() == 0) begin
                    $display("client %0d got a response at %0t with nothing outstanding",
                             c, $time);
                    err_cnt++;
                end else begin
                    e = exp_q[c].pop_front();
                    compare_values($sformatf("client %0d read data", c), rsp[c].rdata, e.data);
                    compare_values("latency within bound", (now - e.acc) <= e.limit, 1);
                    // already queued at the previous grant, so one frame later
                    if (e.acc <= last_rsp[c] - 1) begin
                        compare_values("gap between queued responses", now - last_rsp[c], 16);
                    end
                    last_rsp[c] = now;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, responses stopped coming", LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int       errs;
        int       cpu_high;
        bus_req_t r;
        void'($urandom(60));
        rst       = 1'b1;
        req_valid = '0;
        req       = '0;
        cyc       = 0;
        repeat (3) @(negedge clk);
        compare_values("ready during reset", req_ready, 0);
        rst = 1'b0;

        // 1: bus clock and cpu clock shape
        errs     = err_cnt;
        cpu_high = 0;
        // k counts rising edges since reset was released
        for (int k = 1; k <= 48; k++) begin
            @(negedge clk);
            compare_values("bus clock phase", clk_8, k % 2);
            compare_values("cpu clock in slot 7 only", clk_cpu, (k % 16) == 15);
            cpu_high += clk_cpu;
        end
        compare_values("cpu clock highs in three frames", cpu_high, 3);
        end_test("clocks", errs);

        // 2: read, write, read back on the cpu port
        errs = err_cnt;
        r    = '{addr: 'h020, we: 1'b0, wdata: 8'h00};
        send_req(CLIENT_CPU, r);
        r    = '{addr: 'h020, we: 1'b1, wdata: 8'ha5};
        send_req(CLIENT_CPU, r);
        r    = '{addr: 'h020, we: 1'b0, wdata: 8'h00};
        send_req(CLIENT_CPU, r);
        wait_drain();
        end_test("write then read", errs);

        // 3: all clients at once
        errs = err_cnt;
        fork
            drive_random(CLIENT_CPU);
            drive_random(CLIENT_VIDEO);
            drive_random(CLIENT_SPI);
        join
        wait_drain();
        end_test("random traffic", errs);

        // 4: spi floods back to back writes
        errs = err_cnt;
        stall_seen[CLIENT_SPI] = 1'b0;
        for (int i = 0; i < N_FLOOD; i++) begin
            r = '{addr: bus_addr_t'('h900 + i % 4), we: 1'b1, wdata: 8'(i * 7 + 1)};
            send_req(CLIENT_SPI, r);
        end
        wait_drain();
        compare_values("spi ready dropped when full", stall_seen[CLIENT_SPI], 1);
        end_test("flood", errs);

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_ok, tests_bad, err_cnt);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
